//--- verilog/cpu_types_pkg.sv
package cpu_types_pkg;

	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int alu_op_w   = 4;

	// primary opcodes
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti  = 6'h0A;
	localparam logic [5:0] op_sltiu = 6'h0B;
	localparam logic [5:0] op_andi  = 6'h0C;
	localparam logic [5:0] op_ori   = 6'h0D;
	localparam logic [5:0] op_xori  = 6'h0E;
	localparam logic [5:0] op_lui   = 6'h0F;
	localparam logic [5:0] op_halt  = 6'h3F;

	// function codes under op_rtype
	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_sra  = 6'h03;
	localparam logic [5:0] fn_sllv = 6'h04;
	localparam logic [5:0] fn_jr   = 6'h08;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_nor  = 6'h27;
	localparam logic [5:0] fn_slt  = 6'h2A;
	localparam logic [5:0] fn_sltu = 6'h2B;

	localparam logic [alu_op_w-1:0] alu_sll  = 4'd0;
	localparam logic [alu_op_w-1:0] alu_srl  = 4'd1;
	localparam logic [alu_op_w-1:0] alu_sra  = 4'd2;
	localparam logic [alu_op_w-1:0] alu_add  = 4'd3;
	localparam logic [alu_op_w-1:0] alu_sub  = 4'd4;
	localparam logic [alu_op_w-1:0] alu_and  = 4'd5;
	localparam logic [alu_op_w-1:0] alu_or   = 4'd6;
	localparam logic [alu_op_w-1:0] alu_xor  = 4'd7;
	localparam logic [alu_op_w-1:0] alu_nor  = 4'd8;
	localparam logic [alu_op_w-1:0] alu_slt  = 4'd9;
	localparam logic [alu_op_w-1:0] alu_sltu = 4'd10;
	localparam logic [alu_op_w-1:0] alu_lui  = 4'd11;

	// one instruction word, two field layouts
	typedef union packed {
		struct packed {
			logic [5:0]            opcode;
			logic [reg_addr_w-1:0] rs;
			logic [reg_addr_w-1:0] rt;
			logic [reg_addr_w-1:0] rd;
			logic [reg_addr_w-1:0] shamt;
			logic [5:0]            funct;
		} r;
		struct packed {
			logic [5:0]            opcode;
			logic [reg_addr_w-1:0] rs;
			logic [reg_addr_w-1:0] rt;
			logic [15:0]           imm; // J target is {rs, rt, imm}
		} i;
	} instr_u;

endpackage

//--- verilog/register_file.sv
`timescale 1ns/1ns

module register_file (
	input logic CLK,
	input logic nRST,
	input logic [cpu_types_pkg::reg_addr_w-1:0] rsel1,
	input logic [cpu_types_pkg::reg_addr_w-1:0] rsel2,
	output logic [cpu_types_pkg::word_w-1:0] rdat1,
	output logic [cpu_types_pkg::word_w-1:0] rdat2,
	input logic wen,
	input logic [cpu_types_pkg::reg_addr_w-1:0] wsel,
	input logic [cpu_types_pkg::word_w-1:0] wdat
);
	import cpu_types_pkg::*;

	logic [word_w-1:0] regs [32];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && wsel != '0) begin
			regs[wsel] <= wdat; // r0 never written
		end
	end

	assign rdat1 = (rsel1 == '0) ? '0
		: (wen && wsel == rsel1) ? wdat // write-through from the result register
		: regs[rsel1];
	assign rdat2 = (rsel2 == '0) ? '0
		: (wen && wsel == rsel2) ? wdat
		: regs[rsel2];

endmodule

//--- verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input cpu_types_pkg::instr_u instr,
	input logic [cpu_types_pkg::word_w-1:0] pc,
	input logic [cpu_types_pkg::word_w-1:0] rdat1,
	input logic [cpu_types_pkg::word_w-1:0] rdat2,
	output logic [cpu_types_pkg::reg_addr_w-1:0] rsel1,
	output logic [cpu_types_pkg::reg_addr_w-1:0] rsel2,
	output logic [cpu_types_pkg::word_w-1:0] pcplus4,
	output logic [cpu_types_pkg::word_w-1:0] rs_data,
	output logic [cpu_types_pkg::word_w-1:0] rt_data,
	output logic [cpu_types_pkg::word_w-1:0] immext,
	output logic [cpu_types_pkg::reg_addr_w-1:0] shamt,
	output logic [cpu_types_pkg::alu_op_w-1:0] alu_op,
	output logic alu_src,
	output logic [cpu_types_pkg::reg_addr_w-1:0] write_reg,
	output logic reg_wen,
	output logic is_branch,
	output logic branch_ne,
	output logic is_jump,
	output logic jump_reg,
	output logic [cpu_types_pkg::word_w-1:0] jump_target,
	output logic link,
	output logic halt
);
	import cpu_types_pkg::*;

	logic sign_ext;

	assign rsel1 = instr.r.rs;
	assign rsel2 = instr.r.rt;
	assign rs_data = rdat1;
	assign rt_data = rdat2;
	assign shamt = instr.r.shamt;
	assign pcplus4 = pc + 32'd4;
	assign immext = sign_ext ? {{16{instr.i.imm[15]}}, instr.i.imm} : {16'b0, instr.i.imm};
	assign jump_target = {pcplus4[31:28], instr.i.rs, instr.i.rt, instr.i.imm, 2'b00};

	always_comb begin
		alu_op = alu_add;
		alu_src = 1'b0; // for shifts this picks shamt over rs
		sign_ext = 1'b1;
		write_reg = instr.i.rt;
		reg_wen = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		is_jump = 1'b0;
		jump_reg = 1'b0;
		link = 1'b0;
		halt = 1'b0;
		case (instr.r.opcode)
			op_rtype: begin
				write_reg = instr.r.rd;
				reg_wen = 1'b1;
				case (instr.r.funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_nor:  alu_op = alu_nor;
					fn_slt:  alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_sll: begin
						alu_op = alu_sll;
						alu_src = 1'b1;
					end
					fn_srl: begin
						alu_op = alu_srl;
						alu_src = 1'b1;
					end
					fn_sra: begin
						alu_op = alu_sra;
						alu_src = 1'b1;
					end
					fn_sllv: alu_op = alu_sll;
					fn_jr: begin
						is_jump = 1'b1;
						jump_reg = 1'b1;
						reg_wen = 1'b0;
					end
					default: reg_wen = 1'b0;
				endcase
			end
			op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
				alu_src = 1'b1;
				reg_wen = 1'b1;
				case (instr.i.opcode)
					op_slti:  alu_op = alu_slt;
					op_sltiu: alu_op = alu_sltu;
					op_andi:  alu_op = alu_and;
					op_ori:   alu_op = alu_or;
					op_xori:  alu_op = alu_xor;
					op_lui:   alu_op = alu_lui;
					default:  alu_op = alu_add;
				endcase
				// logical immediates are zero extended
				sign_ext = !(instr.i.opcode inside {op_andi, op_ori, op_xori});
			end
			op_beq, op_bne: begin
				is_branch = 1'b1;
				branch_ne = instr.i.opcode == op_bne;
			end
			op_j: is_jump = 1'b1;
			op_jal: begin
				is_jump = 1'b1;
				link = 1'b1;
				write_reg = 5'd31;
				reg_wen = 1'b1;
			end
			op_halt: halt = 1'b1;
			default: ; // no-op
		endcase
		if (write_reg == '0)
			reg_wen = 1'b0;
	end

endmodule

//--- verilog/idex.sv
`timescale 1ns/1ns

module idex (
	input logic CLK,
	input logic nRST,
	input logic instr_valid,
	input logic flush,
	input logic halted,
	input logic [cpu_types_pkg::word_w-1:0] pcplus4_in, rdat1_in, rdat2_in,
	input logic [cpu_types_pkg::word_w-1:0] immext_in, jump_target_in,
	input logic [cpu_types_pkg::reg_addr_w-1:0] shamt_in, write_reg_in, rsel1_in, rsel2_in,
	input logic [cpu_types_pkg::alu_op_w-1:0] alu_op_in,
	input logic alu_src_in, reg_wen_in, is_branch_in, branch_ne_in,
	input logic is_jump_in, jump_reg_in, link_in, halt_in,
	output logic [cpu_types_pkg::word_w-1:0] pcplus4_out, rdat1_out, rdat2_out,
	output logic [cpu_types_pkg::word_w-1:0] immext_out, jump_target_out,
	output logic [cpu_types_pkg::reg_addr_w-1:0] shamt_out, write_reg_out, rsel1_out, rsel2_out,
	output logic [cpu_types_pkg::alu_op_w-1:0] alu_op_out,
	output logic alu_src_out, reg_wen_out, is_branch_out, branch_ne_out,
	output logic is_jump_out, jump_reg_out, link_out, halt_out,
	output logic ex_valid
);
	import cpu_types_pkg::*;

	logic capture;

	assign capture = instr_valid && !halted && !flush;

	// operand and routing fields hold when nothing is strobed
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pcplus4_out <= '0;
			rdat1_out <= '0;
			rdat2_out <= '0;
			immext_out <= '0;
			jump_target_out <= '0;
			shamt_out <= '0;
			write_reg_out <= '0;
			rsel1_out <= '0;
			rsel2_out <= '0;
			alu_op_out <= alu_sll;
			alu_src_out <= 1'b0;
		end else if (flush) begin
			pcplus4_out <= '0;
			rdat1_out <= '0;
			rdat2_out <= '0;
			immext_out <= '0;
			jump_target_out <= '0;
			shamt_out <= '0;
			write_reg_out <= '0;
			rsel1_out <= '0;
			rsel2_out <= '0;
			alu_op_out <= alu_sll;
			alu_src_out <= 1'b0;
		end else if (capture) begin
			pcplus4_out <= pcplus4_in;
			rdat1_out <= rdat1_in;
			rdat2_out <= rdat2_in;
			immext_out <= immext_in;
			jump_target_out <= jump_target_in;
			shamt_out <= shamt_in;
			write_reg_out <= write_reg_in;
			rsel1_out <= rsel1_in;
			rsel2_out <= rsel2_in;
			alu_op_out <= alu_op_in;
			alu_src_out <= alu_src_in;
		end
	end

	// control drops to zero unless a new instruction is taken
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ex_valid <= 1'b0;
			reg_wen_out <= 1'b0;
			is_branch_out <= 1'b0;
			branch_ne_out <= 1'b0;
			is_jump_out <= 1'b0;
			jump_reg_out <= 1'b0;
			link_out <= 1'b0;
			halt_out <= 1'b0;
		end else begin
			ex_valid <= capture;
			reg_wen_out <= capture && reg_wen_in;
			is_branch_out <= capture && is_branch_in;
			branch_ne_out <= capture && branch_ne_in;
			is_jump_out <= capture && is_jump_in;
			jump_reg_out <= capture && jump_reg_in;
			link_out <= capture && link_in;
			halt_out <= capture && halt_in;
		end
	end

endmodule

//--- verilog/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
	input logic CLK,
	input logic nRST,
	input logic ex_valid,
	input logic [cpu_types_pkg::word_w-1:0] pcplus4,
	input logic [cpu_types_pkg::word_w-1:0] rdat1,
	input logic [cpu_types_pkg::word_w-1:0] rdat2,
	input logic [cpu_types_pkg::word_w-1:0] immext,
	input logic [cpu_types_pkg::word_w-1:0] jump_target,
	input logic [cpu_types_pkg::reg_addr_w-1:0] shamt,
	input logic [cpu_types_pkg::reg_addr_w-1:0] write_reg,
	input logic [cpu_types_pkg::reg_addr_w-1:0] rsel1,
	input logic [cpu_types_pkg::reg_addr_w-1:0] rsel2,
	input logic [cpu_types_pkg::alu_op_w-1:0] alu_op,
	input logic alu_src,
	input logic reg_wen,
	input logic is_branch,
	input logic branch_ne,
	input logic is_jump,
	input logic jump_reg,
	input logic link,
	input logic halt,
	output logic flush,
	output logic result_valid,
	output logic [cpu_types_pkg::reg_addr_w-1:0] result_reg,
	output logic [cpu_types_pkg::word_w-1:0] result_data,
	output logic redirect_valid,
	output logic [cpu_types_pkg::word_w-1:0] redirect_pc,
	output logic halted
);
	import cpu_types_pkg::*;

	logic [word_w-1:0] op1, op2, opb, alu_res, target;
	logic [reg_addr_w-1:0] sh;
	logic is_shift, taken, redirect;

	// previous instruction's result is still in the result register
	assign op1 = (result_valid && result_reg == rsel1) ? result_data : rdat1;
	assign op2 = (result_valid && result_reg == rsel2) ? result_data : rdat2;

	assign is_shift = alu_op inside {alu_sll, alu_srl, alu_sra};
	assign opb = (alu_src && !is_shift) ? immext : op2;
	assign sh = alu_src ? shamt : op1[reg_addr_w-1:0]; // shamt or rs for sllv

	always_comb begin
		case (alu_op)
			alu_add:  alu_res = op1 + opb;
			alu_sub:  alu_res = op1 - opb;
			alu_and:  alu_res = op1 & opb;
			alu_or:   alu_res = op1 | opb;
			alu_xor:  alu_res = op1 ^ opb;
			alu_nor:  alu_res = ~(op1 | opb);
			alu_slt:  alu_res = {{(word_w-1){1'b0}}, $signed(op1) < $signed(opb)};
			alu_sltu: alu_res = {{(word_w-1){1'b0}}, op1 < opb};
			alu_sll:  alu_res = opb << sh;
			alu_srl:  alu_res = opb >> sh;
			alu_sra:  alu_res = $signed(opb) >>> sh;
			alu_lui:  alu_res = {opb[word_w/2-1:0], {(word_w/2){1'b0}}};
			default:  alu_res = '0;
		endcase
	end

	assign taken = is_branch && ((op1 == op2) != branch_ne);
	assign redirect = ex_valid && (taken || is_jump);
	assign target = is_jump ? (jump_reg ? op1 : jump_target)
		: pcplus4 + {immext[word_w-3:0], 2'b00};
	assign flush = ex_valid && (taken || is_jump || halt);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			result_valid <= 1'b0;
			result_reg <= '0;
			redirect_valid <= 1'b0;
			halted <= 1'b0;
		end else begin
			result_valid <= ex_valid && reg_wen;
			result_reg <= write_reg;
			redirect_valid <= redirect;
			halted <= halted || (ex_valid && halt); // sticky until reset
		end
	end

	always_ff @(posedge CLK) begin
		result_data <= link ? pcplus4 : alu_res; // jal links pc+4
		redirect_pc <= target;
	end

endmodule

//--- verilog/id_ex_core.sv
`timescale 1ns/1ns

module id_ex_core (
	input logic CLK,
	input logic nRST,
	input logic instr_valid,
	input logic [cpu_types_pkg::word_w-1:0] instr,
	input logic [cpu_types_pkg::word_w-1:0] pc,
	output logic result_valid,
	output logic [cpu_types_pkg::reg_addr_w-1:0] result_reg,
	output logic [cpu_types_pkg::word_w-1:0] result_data,
	output logic redirect_valid,
	output logic [cpu_types_pkg::word_w-1:0] redirect_pc,
	output logic halted
);
	import cpu_types_pkg::*;

	logic [word_w-1:0] rdat1, rdat2;
	logic flush, ex_valid;
	logic [word_w-1:0] pcplus4_in, rdat1_in, rdat2_in, immext_in, jump_target_in;
	logic [reg_addr_w-1:0] shamt_in, write_reg_in, rsel1_in, rsel2_in;
	logic [alu_op_w-1:0] alu_op_in;
	logic alu_src_in, reg_wen_in, is_branch_in, branch_ne_in;
	logic is_jump_in, jump_reg_in, link_in, halt_in;
	logic [word_w-1:0] pcplus4_out, rdat1_out, rdat2_out, immext_out, jump_target_out;
	logic [reg_addr_w-1:0] shamt_out, write_reg_out, rsel1_out, rsel2_out;
	logic [alu_op_w-1:0] alu_op_out;
	logic alu_src_out, reg_wen_out, is_branch_out, branch_ne_out;
	logic is_jump_out, jump_reg_out, link_out, halt_out;

	decode_stage u_decode (
		.instr(instr), .pc(pc), .rdat1(rdat1), .rdat2(rdat2),
		.rsel1(rsel1_in), .rsel2(rsel2_in),
		.pcplus4(pcplus4_in), .rs_data(rdat1_in), .rt_data(rdat2_in),
		.immext(immext_in), .shamt(shamt_in), .alu_op(alu_op_in), .alu_src(alu_src_in),
		.write_reg(write_reg_in), .reg_wen(reg_wen_in),
		.is_branch(is_branch_in), .branch_ne(branch_ne_in),
		.is_jump(is_jump_in), .jump_reg(jump_reg_in), .jump_target(jump_target_in),
		.link(link_in), .halt(halt_in)
	);

	// result register doubles as the write port
	register_file u_regs (
		.CLK(CLK), .nRST(nRST),
		.rsel1(rsel1_in), .rsel2(rsel2_in), .rdat1(rdat1), .rdat2(rdat2),
		.wen(result_valid), .wsel(result_reg), .wdat(result_data)
	);

	idex u_idex (.*);

	execute_stage u_exec (
		.CLK(CLK), .nRST(nRST), .ex_valid(ex_valid),
		.pcplus4(pcplus4_out), .rdat1(rdat1_out), .rdat2(rdat2_out),
		.immext(immext_out), .jump_target(jump_target_out), .shamt(shamt_out),
		.write_reg(write_reg_out), .rsel1(rsel1_out), .rsel2(rsel2_out),
		.alu_op(alu_op_out), .alu_src(alu_src_out), .reg_wen(reg_wen_out),
		.is_branch(is_branch_out), .branch_ne(branch_ne_out),
		.is_jump(is_jump_out), .jump_reg(jump_reg_out), .link(link_out), .halt(halt_out),
		.flush(flush), .result_valid(result_valid), .result_reg(result_reg),
		.result_data(result_data), .redirect_valid(redirect_valid),
		.redirect_pc(redirect_pc), .halted(halted)
	);

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK; // 100 ns period
	end

	initial begin
		nRST = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK) nRST = 1'b1; // release away from the active edge
	end

endmodule

//--- dv/idex_chk.sv
`timescale 1ns/1ns

module idex_chk (
	input logic CLK,
	input logic nRST,
	input logic result_valid,
	input logic [cpu_types_pkg::reg_addr_w-1:0] result_reg,
	input logic redirect_valid,
	input logic halted
);

	// r0 is never a writeback target
	result_reg_nonzero: assert property (@(posedge CLK) disable iff (!nRST)
		result_valid |-> result_reg != '0)
		else $error("result_valid with result_reg at zero");

	redirect_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
		redirect_valid |=> !redirect_valid)
		else $error("redirect_valid held for more than one cycle");

	quiet_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(halted) |-> ##2 !result_valid)
		else $error("result_valid two cycles after halted rose");

	halted_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		halted |=> halted)
		else $error("halted fell without reset");

endmodule

bind id_ex_core idex_chk chk (.*);

//--- dv/core_tb.sv
`timescale 1ns/1ns

module core_tb;
	import cpu_types_pkg::*;

	logic CLK, nRST;
	logic instr_valid;
	logic [word_w-1:0] instr, pc;
	logic result_valid, redirect_valid, halted;
	logic [reg_addr_w-1:0] result_reg;
	logic [word_w-1:0] result_data, redirect_pc;

	logic [word_w-1:0] ref_regs [32];
	logic [word_w-1:0] lfsr = 32'h9470_7c39;
	logic [word_w-1:0] pc_next = 32'h0000_0100;
	int cyc = 0;
	int issued = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	// expected results and redirects in issue order
	int res_cyc[$];
	logic [reg_addr_w-1:0] res_reg[$];
	logic [word_w-1:0] res_dat[$];
	int rd_cyc[$];
	logic [word_w-1:0] rd_pc[$];

	tb_clock clkgen (.CLK(CLK), .nRST(nRST));
	id_ex_core dut (.*);

	always @(posedge CLK)
		cyc <= cyc + 1;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1; // galois step
		end
		return v;
	endfunction

	function automatic instr_u r_word(input logic [5:0] fn, input logic [4:0] rs, rt, rd, sa);
		instr_u w;
		w = '0;
		w.r.opcode = op_rtype;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = sa;
		w.r.funct = fn;
		return w;
	endfunction

	function automatic instr_u i_word(input logic [5:0] op, input logic [4:0] rs, rt,
			input logic [15:0] imm);
		instr_u w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic instr_u j_word(input logic [5:0] op, input logic [25:0] target);
		instr_u w;
		w.i.opcode = op;
		{w.i.rs, w.i.rt, w.i.imm} = target;
		return w;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED t=%0t %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic expect_true(input bit cond, input string msg);
		checks++;
		assert (cond) else begin
			$display("ERROR t=%0t %s", $time, msg);
			errors++;
		end
	endtask

	// sequential MIPS model queued for the cycle the result must show up
	task automatic run_model(input instr_u w, input logic [31:0] at_pc, input int at_cyc);
		logic [31:0] a, b, simm, zimm, pc4, res, tgt;
		logic [4:0] dst;
		bit wr, jump;
		a = ref_regs[w.r.rs];
		b = ref_regs[w.r.rt];
		simm = {{16{w.i.imm[15]}}, w.i.imm};
		zimm = {16'h0, w.i.imm};
		pc4 = at_pc + 32'd4;
		res = '0;
		dst = w.i.rt;
		jump = 1'b0;
		tgt = pc4 + (simm << 2);
		wr = w.i.opcode inside {op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui};
		case (w.r.opcode)
			op_rtype: begin
				dst = w.r.rd;
				wr = 1'b1;
				case (w.r.funct)
					fn_addu: res = a + b;
					fn_subu: res = a - b;
					fn_and:  res = a & b;
					fn_or:   res = a | b;
					fn_xor:  res = a ^ b;
					fn_nor:  res = ~(a | b);
					fn_slt:  res = {31'b0, $signed(a) < $signed(b)};
					fn_sltu: res = {31'b0, a < b};
					fn_sll:  res = b << w.r.shamt;
					fn_srl:  res = b >> w.r.shamt;
					fn_sra:  res = $signed(b) >>> w.r.shamt;
					fn_sllv: res = b << a[4:0];
					fn_jr: begin
						wr = 1'b0;
						jump = 1'b1;
						tgt = a;
					end
					default: wr = 1'b0;
				endcase
			end
			op_addiu: res = a + simm;
			op_slti:  res = {31'b0, $signed(a) < $signed(simm)};
			op_sltiu: res = {31'b0, a < simm};
			op_andi:  res = a & zimm;
			op_ori:   res = a | zimm;
			op_xori:  res = a ^ zimm;
			op_lui:   res = {w.i.imm, 16'h0};
			op_beq:   jump = a == b;
			op_bne:   jump = a != b;
			op_j, op_jal: begin
				jump = 1'b1;
				tgt = {pc4[31:28], w.i.rs, w.i.rt, w.i.imm, 2'b00};
				if (w.i.opcode == op_jal) begin
					wr = 1'b1;
					dst = 5'd31;
					res = pc4;
				end
			end
			default: ;
		endcase
		if (wr && dst != '0) begin
			ref_regs[dst] = res;
			res_cyc.push_back(at_cyc + 2);
			res_reg.push_back(dst);
			res_dat.push_back(res);
		end
		if (jump) begin
			rd_cyc.push_back(at_cyc + 2);
			rd_pc.push_back(tgt);
		end
	endtask

	// executes low means the core must discard this strobe
	task automatic issue(input instr_u w, input bit executes);
		@(negedge CLK);
		instr_valid = 1'b1;
		instr = w;
		pc = pc_next;
		issued++;
		if (executes)
			run_model(w, pc_next, cyc);
		pc_next = pc_next + 32'd4;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge CLK) instr_valid = 1'b0;
	endtask

	task automatic one_shot(input instr_u w);
		issue(w, 1'b1);
		idle(2);
	endtask

	task automatic drain_pending();
		int waited;
		waited = 0;
		idle(1);
		while ((res_cyc.size() != 0 || rd_cyc.size() != 0) && waited < 6) begin
			idle(1);
			waited++;
		end
		expect_true(res_cyc.size() == 0, "an expected result never appeared");
		expect_true(rd_cyc.size() == 0, "an expected redirect never appeared");
		res_cyc.delete();
		res_reg.delete();
		res_dat.delete();
		rd_cyc.delete();
		rd_pc.delete();
		idle(2); // room for a stray late result
	endtask

	task automatic score_outputs();
		int c;
		if (result_valid) begin
			expect_true(res_cyc.size() != 0, "result_valid with no result expected");
			if (res_cyc.size() != 0) begin
				c = res_cyc.pop_front();
				check_value("result cycle", cyc, c);
				check_value("result_reg", result_reg, res_reg.pop_front());
				check_value("result_data", result_data, res_dat.pop_front());
			end
		end
		if (redirect_valid) begin
			expect_true(rd_cyc.size() != 0, "redirect_valid with no redirect expected");
			if (rd_cyc.size() != 0) begin
				c = rd_cyc.pop_front();
				check_value("redirect cycle", cyc, c);
				check_value("redirect_pc", redirect_pc, rd_pc.pop_front());
			end
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests_run++;
		$display("test %s: %0d errors", name, errors - start);
	endtask

	task automatic alu_results();
		logic [5:0] r_fns [12];
		logic [5:0] i_ops [7];
		logic [31:0] v;
		int start;
		start = errors;
		r_fns = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu,
			fn_sll, fn_srl, fn_sra, fn_sllv};
		i_ops = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui};
		for (int k = 1; k <= 4; k++) begin
			v = rand_bits(32);
			one_shot(i_word(op_lui, 5'd0, 5'(k), v[31:16]));
			one_shot(i_word(op_ori, 5'(k), 5'(k), v[15:0]));
		end
		v = rand_bits(16);
		one_shot(i_word(op_addiu, 5'd0, 5'd4, v[15:0])); // sign extended load
		for (int k = 0; k < 12; k++) begin
			v = rand_bits(5);
			one_shot(r_word(r_fns[k], 5'(1 + rand_bits(2)), 5'(1 + rand_bits(2)), 5'(k + 5),
				v[4:0]));
		end
		for (int k = 0; k < 7; k++) begin
			v = rand_bits(16);
			one_shot(i_word(i_ops[k], 5'(1 + rand_bits(2)), 5'(k + 17), v[15:0]));
		end
		one_shot(r_word(fn_addu, 5'd1, 5'd2, 5'd0, 5'd0));
		one_shot(i_word(op_ori, 5'd3, 5'd0, 16'h00ff));
		drain_pending();
		report_test("alu_results", start);
	endtask

	task automatic forwarding_chains();
		logic [31:0] v;
		int start;
		start = errors;
		repeat (2) begin
			v = rand_bits(32);
			one_shot(i_word(op_lui, 5'd0, 5'd6, v[31:16]));
			one_shot(i_word(op_addiu, 5'd0, 5'd7, v[15:0]));
			issue(r_word(fn_addu, 5'd6, 5'd7, 5'd8, 5'd0), 1'b1);
			issue(r_word(fn_subu, 5'd8, 5'd6, 5'd9, 5'd0), 1'b1);  // distance 1
			issue(r_word(fn_xor, 5'd8, 5'd9, 5'd10, 5'd0), 1'b1);  // distances 2 and 1
			issue(r_word(fn_or, 5'd8, 5'd10, 5'd11, 5'd0), 1'b1);  // distances 3 and 1
			v = rand_bits(32);
			issue(i_word(op_addiu, 5'd8, 5'd8, v[15:0]), 1'b1);
			issue(i_word(op_addiu, 5'd8, 5'd8, v[31:16]), 1'b1);
			issue(r_word(fn_nor, 5'd8, 5'd9, 5'd12, 5'd0), 1'b1);  // newest r8 wins
			issue(r_word(fn_sllv, 5'd11, 5'd12, 5'd13, 5'd0), 1'b1);
			issue(r_word(fn_sltu, 5'd13, 5'd12, 5'd14, 5'd0), 1'b1);
			issue(r_word(fn_slt, 5'd12, 5'd13, 5'd15, 5'd0), 1'b1);
			drain_pending();
		end
		report_test("forwarding_chains", start);
	endtask

	task automatic branch_checks();
		logic [31:0] v;
		int start;
		start = errors;
		v = rand_bits(16);
		one_shot(i_word(op_addiu, 5'd0, 5'd20, v[15:0]));
		one_shot(i_word(op_addiu, 5'd0, 5'd21, v[15:0]));
		one_shot(i_word(op_xori, 5'd20, 5'd22, 16'h0001));
		pc_next = 32'h0000_1000;
		v = rand_bits(16);
		issue(i_word(op_beq, 5'd20, 5'd21, v[15:0]), 1'b1);  // taken
		issue(i_word(op_addiu, 5'd0, 5'd23, 16'h0005), 1'b0);
		drain_pending();
		issue(i_word(op_beq, 5'd20, 5'd22, v[15:0]), 1'b1);  // not taken
		issue(i_word(op_addiu, 5'd0, 5'd23, 16'h0006), 1'b1);
		drain_pending();
		issue(i_word(op_bne, 5'd20, 5'd22, 16'hfff0), 1'b1); // taken backward
		issue(i_word(op_addiu, 5'd0, 5'd24, 16'h0007), 1'b0);
		drain_pending();
		issue(i_word(op_bne, 5'd20, 5'd21, 16'h0010), 1'b1); // not taken
		issue(i_word(op_addiu, 5'd0, 5'd24, 16'h0008), 1'b1);
		drain_pending();
		issue(i_word(op_addiu, 5'd20, 5'd25, 16'h0000), 1'b1);
		issue(i_word(op_beq, 5'd25, 5'd20, 16'h0020), 1'b1); // compare operand forwarded
		issue(i_word(op_addiu, 5'd0, 5'd25, 16'h0009), 1'b0);
		drain_pending();
		report_test("branch_checks", start);
	endtask

	task automatic jump_checks();
		logic [31:0] v;
		int start;
		start = errors;
		pc_next = 32'h4000_0200;
		v = rand_bits(26);
		issue(j_word(op_j, v[25:0]), 1'b1);
		issue(i_word(op_addiu, 5'd0, 5'd26, 16'h0001), 1'b0);
		drain_pending();
		pc_next = 32'h0000_3000;
		v = rand_bits(26);
		issue(j_word(op_jal, v[25:0]), 1'b1);
		issue(i_word(op_addiu, 5'd0, 5'd27, 16'h0002), 1'b0);
		drain_pending();
		issue(r_word(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0), 1'b1);
		issue(j_word(op_j, 26'h000_0400), 1'b0); // flushed jump must not redirect
		drain_pending();
		issue(i_word(op_addiu, 5'd0, 5'd28, 16'h0440), 1'b1);
		issue(r_word(fn_jr, 5'd28, 5'd0, 5'd0, 5'd0), 1'b1); // target forwarded
		issue(i_word(op_addiu, 5'd0, 5'd27, 16'h0004), 1'b0);
		drain_pending();
		report_test("jump_checks", start);
	endtask

	task automatic halt_checks();
		logic [31:0] v;
		int start;
		start = errors;
		v = rand_bits(16);
		issue(i_word(op_addiu, 5'd0, 5'd29, v[15:0]), 1'b1);
		issue(i_word(op_halt, 5'd0, 5'd0, 16'h0000), 1'b1);
		issue(i_word(op_addiu, 5'd0, 5'd30, 16'h0007), 1'b0); // halt is in execute now
		expect_true(halted == 1'b0, "halted rose before the halt left execute");
		issue(i_word(op_addiu, 5'd0, 5'd30, 16'h0008), 1'b0); // first cycle with halted high
		expect_true(halted == 1'b1, "halted did not rise after the halt executed");
		repeat (3) issue(i_word(op_addiu, 5'd0, 5'd30, 16'h0009), 1'b0);
		drain_pending();
		expect_true(halted == 1'b1, "halted fell while the core was halted");
		report_test("halt_checks", start);
	endtask

	initial begin
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		for (int k = 0; k < 32; k++)
			ref_regs[k] = '0;
		wait (nRST === 1'b1);
		alu_results();
		forwarding_chains();
		branch_checks();
		jump_checks();
		halt_checks(); // runs last since halted only clears on reset
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		forever begin
			@(negedge CLK);
			if (nRST)
				score_outputs();
		end
	end

	// 40 cycles per issued instruction
	initial begin
		wait (cyc > 40 * (issued + 1));
		$display("ERROR watchdog expired after %0d cycles, %0d instructions issued", cyc, issued);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- mips_idex.f
verilog/cpu_types_pkg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/idex.sv
verilog/execute_stage.sv
verilog/id_ex_core.sv
dv/tb_clock.sv
dv/idex_chk.sv
dv/core_tb.sv
